// ==== rtl/calc_pkg.sv ====
//--------------------
// Calculator shared definitions
// Widths, completion stage layout, opcodes and state encodings
//--------------------

package calc_pkg;

  localparam int XLEN        = 32;
  localparam int REG_ADDR_W  = 5;
  localparam int COMP_STAGES = 4;
  localparam int INT_STAGE   = 1;
  localparam int MUL_STAGE   = 3;
  localparam int WB_STAGE    = 3;
  localparam int SHAMT_W     = $clog2(XLEN);
  localparam int DIV_CNT_W   = $clog2(XLEN);
  localparam int MUL_HALF_W  = XLEN / 2;

  typedef logic [XLEN-1:0]        word_t;
  typedef logic [REG_ADDR_W-1:0]  reg_addr_t;
  typedef logic [COMP_STAGES-1:0] stage_match_t;

  typedef enum logic [3:0]
  {
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
    OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
    OP_MUL,
    OP_DIV, OP_DIVU, OP_REM, OP_REMU
  } calc_op_e;

  typedef enum logic [1:0]
  {
    DIV_IDLE,
    DIV_BUSY,
    DIV_DONE
  } div_state_e;

  function automatic logic is_int_op(calc_op_e op);
    return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                      OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU};
  endfunction

  function automatic logic is_long_op(calc_op_e op);
    return op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
  endfunction

endpackage

// ==== rtl/calc_resv_if.sv ====
//--------------------
// Reservation register bundle
// Carries the issued instruction to the pipes
//--------------------
`timescale 1ns/1ps

interface calc_resv_if
  import calc_pkg::*;
();

  logic      v;
  calc_op_e  op;
  reg_addr_t rd;
  word_t     rs1_data;
  word_t     rs2_data;

  modport resv (output v, op, rd, rs1_data, rs2_data);
  modport pipe (input v, op, rd, rs1_data, rs2_data);

endinterface

// ==== rtl/calc_bypass.sv ====
//--------------------
// Operand bypass and reservation register
// Youngest matching completion stage overrides the register file value
//--------------------
`timescale 1ns/1ps

module calc_bypass
  import calc_pkg::*;
 (input  logic                        clk_i
  , input  logic                        rst_n_i
  , input  logic                        dispatch_v_i
  , input  logic                        flush_i
  , input  calc_op_e                    dispatch_op_i
  , input  reg_addr_t                   dispatch_rd_i
  , input  reg_addr_t                   dispatch_rs1_i
  , input  reg_addr_t                   dispatch_rs2_i
  , input  word_t                       rs1_data_i
  , input  word_t                       rs2_data_i
  , input  stage_match_t                stage_wv_i
  , input  reg_addr_t [COMP_STAGES-1:0] stage_rd_i
  , input  word_t [COMP_STAGES-1:0]     fwd_data_i
  , calc_resv_if.resv                   resv
  );

  stage_match_t rs1_match;
  stage_match_t rs2_match;
  word_t        rs1_byp;
  word_t        rs2_byp;

  // Stage 0 is the youngest, so it is applied last
  function automatic word_t select_youngest(stage_match_t match,
                                            word_t [COMP_STAGES-1:0] fwd,
                                            word_t rf_data);
    word_t data;
    data = rf_data;
    for (int i = COMP_STAGES - 1; i >= 0; i--)
    begin
      if (match[i])
        data = fwd[i];
    end
    return data;
  endfunction

  for (genvar i = 0; i < COMP_STAGES; i++)
  begin : g_match
    assign rs1_match[i] = stage_wv_i[i] & (stage_rd_i[i] == dispatch_rs1_i);
    assign rs2_match[i] = stage_wv_i[i] & (stage_rd_i[i] == dispatch_rs2_i);
  end

  assign rs1_byp = select_youngest(rs1_match, fwd_data_i, rs1_data_i);
  assign rs2_byp = select_youngest(rs2_match, fwd_data_i, rs2_data_i);

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      resv.v <= 1'b0;
    else
      resv.v <= dispatch_v_i & ~flush_i;
  end

  always_ff @(posedge clk_i)
  begin
    resv.op       <= dispatch_op_i;
    resv.rd       <= dispatch_rd_i;
    resv.rs1_data <= rs1_byp;
    resv.rs2_data <= rs2_byp;
  end

endmodule

// ==== rtl/calc_pipe_int.sv ====
//--------------------
// Integer pipe
// Single cycle ALU over the reservation register
//--------------------
`timescale 1ns/1ps

module calc_pipe_int
  import calc_pkg::*;
 (calc_resv_if.pipe resv
  , output word_t    int_data_o
  , output logic     int_v_o
  );

  logic [SHAMT_W-1:0] shamt;

  assign shamt   = resv.rs2_data[SHAMT_W-1:0];
  assign int_v_o = resv.v & is_int_op(resv.op);

  always_comb
  begin
    case (resv.op)
      OP_ADD:
        int_data_o = resv.rs1_data + resv.rs2_data;
      OP_SUB:
        int_data_o = resv.rs1_data - resv.rs2_data;
      OP_AND:
        int_data_o = resv.rs1_data & resv.rs2_data;
      OP_OR:
        int_data_o = resv.rs1_data | resv.rs2_data;
      OP_XOR:
        int_data_o = resv.rs1_data ^ resv.rs2_data;
      OP_SLL:
        int_data_o = resv.rs1_data << shamt;
      OP_SRL:
        int_data_o = resv.rs1_data >> shamt;
      OP_SRA:
        int_data_o = word_t'($signed(resv.rs1_data) >>> shamt);
      // Compares give 0 or 1
      OP_SLT:
        int_data_o = word_t'($signed(resv.rs1_data) < $signed(resv.rs2_data));
      OP_SLTU:
        int_data_o = word_t'(resv.rs1_data < resv.rs2_data);
      default:
        int_data_o = '0;
    endcase
  end

endmodule

// ==== rtl/calc_pipe_mul.sv ====
//--------------------
// Multiply pipe
// Low word product over two register stages
//--------------------
`timescale 1ns/1ps

module calc_pipe_mul
  import calc_pkg::*;
 (input  logic       clk_i
  , input  logic       rst_n_i
  , calc_resv_if.pipe  resv
  , output word_t      mul_data_o
  , output logic       mul_v_o
  );

  word_t                 part_lo_r;
  logic [MUL_HALF_W-1:0] part_hi_r;
  word_t                 prod_r;
  logic                  v1_r;
  logic                  v2_r;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      v1_r <= 1'b0;
      v2_r <= 1'b0;
    end
    else
    begin
      v1_r <= resv.v & (resv.op == OP_MUL);
      v2_r <= v1_r;
    end
  end

  // Upper half of rs2 only reaches the upper half of the low word
  always_ff @(posedge clk_i)
  begin
    part_lo_r <= resv.rs1_data * resv.rs2_data[MUL_HALF_W-1:0];
    part_hi_r <= resv.rs1_data[MUL_HALF_W-1:0] * resv.rs2_data[XLEN-1:MUL_HALF_W];
    prod_r    <= part_lo_r + {part_hi_r, {MUL_HALF_W{1'b0}}};
  end

  assign mul_data_o = prod_r;
  assign mul_v_o    = v2_r;

endmodule

// ==== rtl/calc_pipe_long.sv ====
//--------------------
// Long pipe
// Restoring divider for DIV, DIVU, REM and REMU with a held result
//--------------------
`timescale 1ns/1ps

module calc_pipe_long
  import calc_pkg::*;
 (input  logic       clk_i
  , input  logic       rst_n_i
  , input  logic       flush_i
  , input  logic       long_yumi_i
  , calc_resv_if.pipe  resv
  , output logic       long_ready_o
  , output logic       long_v_o
  , output reg_addr_t  long_rd_o
  , output word_t      long_data_o
  );

  div_state_e           state_r;
  div_state_e           state_n;
  logic [DIV_CNT_W-1:0] cnt_r;
  word_t                quo_r;
  word_t                rem_r;
  word_t                dvsr_r;
  reg_addr_t            rd_r;
  logic                 is_rem_r;
  logic                 quo_neg_r;
  logic                 rem_neg_r;
  logic                 start;
  logic                 is_signed;
  logic                 neg_a;
  logic                 neg_b;
  word_t                abs_a;
  word_t                abs_b;
  logic [XLEN:0]        trial;

  assign start     = resv.v & is_long_op(resv.op) & ~flush_i;
  assign is_signed = (resv.op == OP_DIV) | (resv.op == OP_REM);
  assign neg_a     = is_signed & resv.rs1_data[XLEN-1];
  assign neg_b     = is_signed & resv.rs2_data[XLEN-1];
  assign abs_a     = neg_a ? -resv.rs1_data : resv.rs1_data;
  assign abs_b     = neg_b ? -resv.rs2_data : resv.rs2_data;

  // Shift in the next dividend bit and try the subtract
  assign trial = {rem_r, quo_r[XLEN-1]} - {1'b0, dvsr_r};

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      DIV_IDLE:
        if (start)
          state_n = DIV_BUSY;
      DIV_BUSY:
        if (cnt_r == DIV_CNT_W'(XLEN - 1))
          state_n = DIV_DONE;
      DIV_DONE:
        if (long_yumi_i)
          state_n = DIV_IDLE;
      default:
        state_n = DIV_IDLE;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_r <= DIV_IDLE;
      cnt_r   <= '0;
    end
    else
    begin
      state_r <= state_n;
      cnt_r   <= (state_r == DIV_BUSY) ? cnt_r + 1'b1 : '0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if ((state_r == DIV_IDLE) && start)
    begin
      quo_r     <= abs_a;
      rem_r     <= '0;
      dvsr_r    <= abs_b;
      rd_r      <= resv.rd;
      is_rem_r  <= (resv.op == OP_REM) | (resv.op == OP_REMU);
      // Divide by zero keeps the all ones quotient unsigned
      quo_neg_r <= (neg_a ^ neg_b) & (resv.rs2_data != '0);
      rem_neg_r <= neg_a;
    end
    else if (state_r == DIV_BUSY)
    begin
      if (!trial[XLEN])
      begin
        rem_r <= trial[XLEN-1:0];
        quo_r <= {quo_r[XLEN-2:0], 1'b1};
      end
      else
      begin
        rem_r <= {rem_r[XLEN-2:0], quo_r[XLEN-1]};
        quo_r <= {quo_r[XLEN-2:0], 1'b0};
      end
    end
  end

  assign long_ready_o = (state_r == DIV_IDLE);
  assign long_v_o     = (state_r == DIV_DONE);
  assign long_rd_o    = rd_r;
  assign long_data_o  = is_rem_r ? (rem_neg_r ? -rem_r : rem_r)
                                 : (quo_neg_r ? -quo_r : quo_r);

endmodule

// ==== rtl/calc_comp_pipe.sv ====
//--------------------
// Completion pipeline
// Stage shift with result merge, flush kill and writeback arbitration
//--------------------
`timescale 1ns/1ps

module calc_comp_pipe
  import calc_pkg::*;
 (input  logic                          clk_i
  , input  logic                          rst_n_i
  , input  logic                          flush_i
  , calc_resv_if.pipe                     resv
  , input  word_t                         int_data_i
  , input  logic                          int_v_i
  , input  word_t                         mul_data_i
  , input  logic                          mul_v_i
  , input  logic                          long_v_i
  , input  reg_addr_t                     long_rd_i
  , input  word_t                         long_data_i
  , output logic                          long_yumi_o
  , output stage_match_t                  stage_wv_o
  , output reg_addr_t [COMP_STAGES-1:0]   stage_rd_o
  , output word_t [COMP_STAGES-1:0]       fwd_data_o
  , output logic                          iwb_v_o
  , output reg_addr_t                     iwb_rd_o
  , output word_t                         iwb_data_o
  );

  // Stage 0 is the reservation register itself
  logic [COMP_STAGES-1:1]      wv_r;
  logic [COMP_STAGES-1:1]      wv_n;
  reg_addr_t [COMP_STAGES-1:1] rd_r;
  reg_addr_t [COMP_STAGES-1:1] rd_n;
  word_t [COMP_STAGES-1:1]     data_r;
  word_t [COMP_STAGES:1]       data_n;
  word_t [COMP_STAGES-1:0]     stage_data;

  // Long ops write through the yumi path, never through the stages
  assign stage_wv_o[0] = resv.v & ~is_long_op(resv.op) & (resv.rd != '0);
  assign stage_rd_o[0] = resv.rd;
  assign stage_data[0] = '0;

  assign stage_wv_o[COMP_STAGES-1:1] = wv_r;
  assign stage_rd_o[COMP_STAGES-1:1] = rd_r;
  assign stage_data[COMP_STAGES-1:1] = data_r;

  always_comb
  begin
    for (int i = 1; i <= COMP_STAGES; i++)
    begin
      data_n[i] = stage_data[i-1];
    end
    data_n[INT_STAGE] = int_v_i ? int_data_i : stage_data[INT_STAGE-1];
    data_n[MUL_STAGE] = mul_v_i ? mul_data_i : stage_data[MUL_STAGE-1];

    for (int i = 1; i < COMP_STAGES; i++)
    begin
      rd_n[i] = stage_rd_o[i-1];
      wv_n[i] = stage_wv_o[i-1];
      if (i < WB_STAGE)
        wv_n[i] = wv_n[i] & ~flush_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      wv_r <= '0;
    else
      wv_r <= wv_n;
  end

  always_ff @(posedge clk_i)
  begin
    rd_r   <= rd_n;
    data_r <= data_n[COMP_STAGES-1:1];
  end

  // Stage i forwards the merged value it is about to pass on
  assign fwd_data_o = data_n;

  // Long result only takes the port when the last stage is idle
  assign long_yumi_o = long_v_i & ~wv_r[WB_STAGE];

  assign iwb_v_o    = long_yumi_o ? (long_rd_i != '0) : wv_r[WB_STAGE];
  assign iwb_rd_o   = long_yumi_o ? long_rd_i : rd_r[WB_STAGE];
  assign iwb_data_o = long_yumi_o ? long_data_i : data_r[WB_STAGE];

endmodule

// ==== rtl/calc_top.sv ====
//--------------------
// Calculator top level
// Bypass, execution pipes and completion pipeline
//--------------------
`timescale 1ns/1ps

module calc_top
  import calc_pkg::*;
 (input  logic       clk_i
  , input  logic       rst_n_i
  , input  logic       dispatch_v_i
  , input  calc_op_e   dispatch_op_i
  , input  reg_addr_t  dispatch_rd_i
  , input  reg_addr_t  dispatch_rs1_i
  , input  reg_addr_t  dispatch_rs2_i
  , input  word_t      rs1_data_i
  , input  word_t      rs2_data_i
  , input  logic       flush_i
  , output logic       long_ready_o
  , output logic       iwb_v_o
  , output reg_addr_t  iwb_rd_o
  , output word_t      iwb_data_o
  );

  word_t                       int_data;
  logic                        int_v;
  word_t                       mul_data;
  logic                        mul_v;
  logic                        long_v;
  reg_addr_t                   long_rd;
  word_t                       long_data;
  logic                        long_yumi;
  stage_match_t                stage_wv;
  reg_addr_t [COMP_STAGES-1:0] stage_rd;
  word_t [COMP_STAGES-1:0]     fwd_data;

  calc_resv_if resv_if ();

  calc_bypass bypass
   (.clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.dispatch_v_i(dispatch_v_i)
    ,.flush_i(flush_i)
    ,.dispatch_op_i(dispatch_op_i)
    ,.dispatch_rd_i(dispatch_rd_i)
    ,.dispatch_rs1_i(dispatch_rs1_i)
    ,.dispatch_rs2_i(dispatch_rs2_i)
    ,.rs1_data_i(rs1_data_i)
    ,.rs2_data_i(rs2_data_i)
    ,.stage_wv_i(stage_wv)
    ,.stage_rd_i(stage_rd)
    ,.fwd_data_i(fwd_data)
    ,.resv(resv_if.resv)
    );

  calc_pipe_int pipe_int
   (.resv(resv_if.pipe)
    ,.int_data_o(int_data)
    ,.int_v_o(int_v)
    );

  calc_pipe_mul pipe_mul
   (.clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.resv(resv_if.pipe)
    ,.mul_data_o(mul_data)
    ,.mul_v_o(mul_v)
    );

  calc_pipe_long pipe_long
   (.clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.flush_i(flush_i)
    ,.long_yumi_i(long_yumi)
    ,.resv(resv_if.pipe)
    ,.long_ready_o(long_ready_o)
    ,.long_v_o(long_v)
    ,.long_rd_o(long_rd)
    ,.long_data_o(long_data)
    );

  calc_comp_pipe comp_pipe
   (.clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.flush_i(flush_i)
    ,.resv(resv_if.pipe)
    ,.int_data_i(int_data)
    ,.int_v_i(int_v)
    ,.mul_data_i(mul_data)
    ,.mul_v_i(mul_v)
    ,.long_v_i(long_v)
    ,.long_rd_i(long_rd)
    ,.long_data_i(long_data)
    ,.long_yumi_o(long_yumi)
    ,.stage_wv_o(stage_wv)
    ,.stage_rd_o(stage_rd)
    ,.fwd_data_o(fwd_data)
    ,.iwb_v_o(iwb_v_o)
    ,.iwb_rd_o(iwb_rd_o)
    ,.iwb_data_o(iwb_data_o)
    );

endmodule

// ==== verification/calc_props.sv ====
//--------------------
// Calculator properties
// Reset state, long pipe handshake and flush kill checks
//--------------------
`timescale 1ns/1ps

module calc_props
  import calc_pkg::*;
 (input  logic         clk_i
  , input  logic         rst_n_i
  , input  logic         dispatch_v_i
  , input  calc_op_e     dispatch_op_i
  , input  logic         flush_i
  , input  logic         long_ready_o
  , input  logic         iwb_v_o
  , input  logic         long_v
  , input  logic         long_yumi
  , input  stage_match_t stage_wv
  );

  logic reset_bad = 1'b0;
  logic yumi_bad  = 1'b0;
  logic start_bad = 1'b0;
  logic hold_bad  = 1'b0;
  logic kill_bad  = 1'b0;
  logic any_fail;

  assign any_fail = reset_bad | yumi_bad | start_bad | hold_bad | kill_bad;

  // Idle state right after reset
  a_reset: assert property (@(posedge clk_i)
    !rst_n_i |=> !iwb_v_o && long_ready_o && (stage_wv == '0))
    else
    begin
      reset_bad = 1'b1;
      $error("state not clear after reset");
    end

  // A consumed long result frees the pipe
  a_yumi: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    long_yumi |=> long_ready_o && !long_v)
    else
    begin
      yumi_bad = 1'b1;
      $error("long pipe not free after yumi");
    end

  a_start: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (dispatch_v_i && is_long_op(dispatch_op_i) && !flush_i) ##1 !flush_i |=> !long_ready_o)
    else
    begin
      start_bad = 1'b1;
      $error("long ready did not fall");
    end

  // A held result waits until consumed
  a_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    long_v && !long_yumi |=> long_v)
    else
    begin
      hold_bad = 1'b1;
      $error("long result dropped");
    end

  a_kill: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dispatch_v_i && flush_i && !is_long_op(dispatch_op_i) |-> ##4 !stage_wv[WB_STAGE])
    else
    begin
      kill_bad = 1'b1;
      $error("flushed op reached stage 3");
    end

endmodule

bind calc_top calc_props props
 (.clk_i(clk_i)
  ,.rst_n_i(rst_n_i)
  ,.dispatch_v_i(dispatch_v_i)
  ,.dispatch_op_i(dispatch_op_i)
  ,.flush_i(flush_i)
  ,.long_ready_o(long_ready_o)
  ,.iwb_v_o(iwb_v_o)
  ,.long_v(long_v)
  ,.long_yumi(long_yumi)
  ,.stage_wv(stage_wv)
  );

// ==== verification/calc_tb.sv ====
//--------------------
// Calculator testbench
// Random dispatch with a reference model and a writeback scoreboard
//--------------------
`timescale 1ns/1ps

module calc_tb;
  import calc_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int SEED       = 81672;
  localparam int NUM_INSTR  = 600;
  localparam int TIMEOUT    = 40 * (NUM_INSTR + XLEN);

  logic      clk = 1'b0;
  logic      rst_n;
  logic      dispatch_v;
  calc_op_e  dispatch_op;
  reg_addr_t dispatch_rd;
  reg_addr_t dispatch_rs1;
  reg_addr_t dispatch_rs2;
  word_t     rs1_data;
  word_t     rs2_data;
  logic      flush;
  logic      long_ready;
  logic      iwb_v;
  reg_addr_t iwb_rd;
  word_t     iwb_data;

  // Architectural file from writebacks, model file in program order
  word_t     regs [32];
  word_t     mregs [32];
  int        last_mul [32];
  logic      exp_v [8];
  reg_addr_t exp_rd [8];
  word_t     exp_data [8];
  logic      long_pend = 1'b0;
  reg_addr_t long_rd_q;
  word_t     long_data_q;
  logic [31:0] lfsr = SEED;
  int        cyc = 0;
  int        last_long = -8;
  int        last_disp = -8;
  int        flush_edge = -8;
  int        idle_left = 0;

  calc_top DUT
   (.clk_i(clk), .rst_n_i(rst_n), .dispatch_v_i(dispatch_v), .dispatch_op_i(dispatch_op)
    ,.dispatch_rd_i(dispatch_rd), .dispatch_rs1_i(dispatch_rs1), .dispatch_rs2_i(dispatch_rs2)
    ,.rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .flush_i(flush)
    ,.long_ready_o(long_ready), .iwb_v_o(iwb_v), .iwb_rd_o(iwb_rd), .iwb_data_o(iwb_data));

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic word_t take_bits(int n);
    word_t val;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      val = {val[XLEN-2:0], lfsr[0]};
    end
    return val;
  endfunction

  function automatic word_t expected_result(calc_op_e op, word_t a, word_t b);
    logic ovf;
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SLL:  return a << b[4:0];
      OP_SRL:  return a >> b[4:0];
      OP_SRA:  return word_t'($signed(a) >>> b[4:0]);
      OP_SLT:  return word_t'($signed(a) < $signed(b));
      OP_SLTU: return word_t'(a < b);
      OP_MUL:  return a * b;
      OP_DIV:  return (b == 0) ? '1 : ovf ? a : word_t'($signed(a) / $signed(b));
      OP_DIVU: return (b == 0) ? '1 : a / b;
      OP_REM:  return (b == 0) ? a : ovf ? '0 : word_t'($signed(a) % $signed(b));
      default: return (b == 0) ? a : a % b;
    endcase
  endfunction

  task automatic mismatch_error(string name, word_t got, word_t exp);
    $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic abort_run(string msg);
    $display("t=%0t %s", $time, msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  // One dispatch slot, sampled at edge e
  task automatic issue_slot();
    calc_op_e  op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     res;
    int        e;
    logic      kill;
    e = cyc + 1;
    dispatch_v = 1'b0;
    flush = (e == flush_edge);
    if (idle_left > 0)
    begin
      idle_left--;
      return;
    end
    op = calc_op_e'(take_bits(4) % 15);
    rd = reg_addr_t'(take_bits(5));
    rs1 = reg_addr_t'(take_bits(5));
    rs2 = reg_addr_t'(take_bits(5));
    if (rd == 1 || rd == 2)
      rd = rd + 8;
    if (take_bits(3) == 0)
      rs2 = 0;
    if (is_long_op(op))
    begin
      if (!long_ready || long_pend || last_long == e - 1)
        return;
      // Signed overflow operands
      if (take_bits(3) == 0)
      begin
        rs1 = 1;
        rs2 = 2;
      end
    end
    if (long_pend && (rd == long_rd_q || rs1 == long_rd_q || rs2 == long_rd_q))
      return;
    if (e - last_mul[rs1] < 3 || e - last_mul[rs2] < 3)
      return;
    kill = (take_bits(4) == 0) && (e - last_disp >= 3);
    dispatch_v = 1'b1;
    dispatch_op = op;
    dispatch_rd = rd;
    dispatch_rs1 = rs1;
    dispatch_rs2 = rs2;
    rs1_data = regs[rs1];
    rs2_data = regs[rs2];
    if (is_long_op(op))
      last_long = e;
    if (kill)
    begin
      flush_edge = e + int'(take_bits(2)) % (is_long_op(op) ? 2 : 3);
      flush = (e == flush_edge);
      idle_left = 2;
      return;
    end
    last_disp = e;
    res = expected_result(op, mregs[rs1], mregs[rs2]);
    if (rd != 0)
      mregs[rd] = res;
    if (op == OP_MUL)
      last_mul[rd] = e;
    if (is_long_op(op))
    begin
      // A long op to x0 never shows up on the write port
      long_pend = (rd != 0);
      long_rd_q = rd;
      long_data_q = res;
    end
    else if (rd != 0)
    begin
      exp_v[(e + 3) % 8] = 1'b1;
      exp_rd[(e + 3) % 8] = rd;
      exp_data[(e + 3) % 8] = res;
    end
  endtask

  always @(posedge clk)
  begin
    cyc <= cyc + 1;
    if (cyc > TIMEOUT)
      abort_run("timeout waiting for the run to finish");
  end

  // Outputs are stable at the falling edge
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (DUT.props.any_fail)
        abort_run("bound assertion failed");
      if (exp_v[cyc % 8])
      begin
        assert (iwb_v) else mismatch_error("iwb_v_o", word_t'(iwb_v), 1);
        assert (iwb_rd == exp_rd[cyc % 8])
          else mismatch_error("iwb_rd_o", iwb_rd, exp_rd[cyc % 8]);
        assert (iwb_data == exp_data[cyc % 8])
          else mismatch_error("iwb_data_o", iwb_data, exp_data[cyc % 8]);
        regs[iwb_rd] = iwb_data;
        exp_v[cyc % 8] = 1'b0;
      end
      else if (iwb_v)
      begin
        assert (long_pend) else abort_run("write on iwb with no instruction due");
        assert (iwb_rd == long_rd_q) else mismatch_error("iwb_rd_o", iwb_rd, long_rd_q);
        assert (iwb_data == long_data_q)
          else mismatch_error("iwb_data_o", iwb_data, long_data_q);
        regs[iwb_rd] = iwb_data;
        long_pend = 1'b0;
      end
    end
  end

  initial
  begin
    rst_n = 1'b0;
    dispatch_v = 1'b0;
    dispatch_op = OP_ADD;
    dispatch_rd = '0;
    dispatch_rs1 = '0;
    dispatch_rs2 = '0;
    rs1_data = '0;
    rs2_data = '0;
    flush = 1'b0;
    for (int i = 0; i < 32; i++)
    begin
      regs[i] = take_bits(XLEN);
      last_mul[i] = -8;
    end
    for (int i = 0; i < 8; i++)
      exp_v[i] = 1'b0;
    regs[0] = '0;
    regs[1] = 32'h8000_0000;
    regs[2] = 32'hffff_ffff;
    mregs = regs;
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
    for (int n = 0; n < NUM_INSTR; n++)
    begin
      @(posedge clk);
      #1 issue_slot();
    end
    // Idle slots still raise a flush that is due
    idle_left = 3;
    repeat (3)
    begin
      @(posedge clk);
      #1 issue_slot();
    end
    while (long_pend)
      @(posedge clk);
    repeat (6) @(posedge clk);
    if (DUT.props.any_fail)
    begin
      $display("Simulation failed");
      $fatal(1);
    end
    else
    begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

// ==== sources.f ====
rtl/calc_pkg.sv
rtl/calc_resv_if.sv
rtl/calc_bypass.sv
rtl/calc_pipe_int.sv
rtl/calc_pipe_mul.sv
rtl/calc_pipe_long.sv
rtl/calc_comp_pipe.sv
rtl/calc_top.sv
verification/calc_props.sv
verification/calc_tb.sv

// ==== Makefile ====
# Verilator build and run for the calculator testbench

OBJ_DIR := obj_dir
SIM     := calc_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		-f sources.f --top-module calc_tb \
		-Mdir $(OBJ_DIR) -o $(SIM)

run: compile
	./$(OBJ_DIR)/$(SIM)

clean:
	rm -rf $(OBJ_DIR)
